/* verilog/simd_elem_pkg.sv */
package simd_elem_pkg;

  localparam int unsigned DataWidth = 64;
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned StrbWidth = DataWidth / ByteWidth;

  typedef logic [DataWidth-1:0] elen_t;
  typedef logic [StrbWidth-1:0] strb_t;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Bytes per element
  function automatic int elem_bytes(vew_e ew);
    return 1 << ew;
  endfunction

  // Lowest byte of the element that holds byte idx
  function automatic int elem_base(vew_e ew, int idx);
    return idx & ~(elem_bytes(ew) - 1);
  endfunction

endpackage

/* verilog/simd_op_pkg.sv */
package simd_op_pkg;

  // Numeric codes are shared with the golden vectors
  typedef enum logic [4:0] {
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADD,
    OP_SUB,
    OP_RSUB,
    OP_SADDU,
    OP_SADD,
    OP_SSUBU,
    OP_SSUB,
    OP_MINU,
    OP_MIN,
    OP_MAXU,
    OP_MAX,
    OP_MSEQ,
    OP_MSNE,
    OP_MSLTU,
    OP_MSLT,
    OP_MSLEU,
    OP_MSLE,
    OP_MSGTU,
    OP_MSGT,
    OP_SLL,
    OP_SRL,
    OP_SRA
  } alu_op_e;

  // Unit that produces the result
  typedef enum logic [2:0] {
    CLS_NONE,
    CLS_LOGIC,
    CLS_ARITH,
    CLS_MINMAX,
    CLS_CMP,
    CLS_SHIFT
  } alu_class_e;

endpackage

/* verilog/simd_alu_issue.sv */
`timescale 1ns/10ps

module simd_alu_issue (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  simd_op_pkg::alu_op_e    op_i,
  input  simd_elem_pkg::vew_e     vew_i,
  input  simd_elem_pkg::elen_t    operand_a_i,
  input  simd_elem_pkg::elen_t    operand_b_i,
  output logic                    valid_o,
  output simd_op_pkg::alu_class_e class_o,
  output simd_op_pkg::alu_op_e    op_o,
  output simd_elem_pkg::vew_e     vew_o,
  output logic                    signed_o,
  output logic                    subtract_o,
  output logic                    reverse_o,
  output logic                    saturate_o,
  output simd_elem_pkg::elen_t    operand_a_o,
  output simd_elem_pkg::elen_t    operand_b_o
);

  simd_op_pkg::alu_class_e class_d;
  logic                    signed_d;
  logic                    subtract_d;
  logic                    reverse_d;
  logic                    saturate_d;

  always_comb begin : p_decode
    if (op_i inside {[simd_op_pkg::OP_AND : simd_op_pkg::OP_XOR]}) begin
      class_d = simd_op_pkg::CLS_LOGIC;
    end else if (op_i inside {[simd_op_pkg::OP_ADD : simd_op_pkg::OP_SSUB]}) begin
      class_d = simd_op_pkg::CLS_ARITH;
    end else if (op_i inside {[simd_op_pkg::OP_MINU : simd_op_pkg::OP_MAX]}) begin
      class_d = simd_op_pkg::CLS_MINMAX;
    end else if (op_i inside {[simd_op_pkg::OP_MSEQ : simd_op_pkg::OP_MSGT]}) begin
      class_d = simd_op_pkg::CLS_CMP;
    end else if (op_i inside {[simd_op_pkg::OP_SLL : simd_op_pkg::OP_SRA]}) begin
      class_d = simd_op_pkg::CLS_SHIFT;
    end else begin
      class_d = simd_op_pkg::CLS_NONE;
    end
  end

  // Signedness covers saturation, min/max and ordered compares
  assign signed_d   = op_i inside {simd_op_pkg::OP_SADD, simd_op_pkg::OP_SSUB,
                                   simd_op_pkg::OP_MIN, simd_op_pkg::OP_MAX,
                                   simd_op_pkg::OP_MSLT, simd_op_pkg::OP_MSLE,
                                   simd_op_pkg::OP_MSGT};
  assign subtract_d = op_i inside {simd_op_pkg::OP_SUB, simd_op_pkg::OP_RSUB,
                                   simd_op_pkg::OP_SSUBU, simd_op_pkg::OP_SSUB};
  assign reverse_d  = op_i == simd_op_pkg::OP_RSUB;
  assign saturate_d = op_i inside {[simd_op_pkg::OP_SADDU : simd_op_pkg::OP_SSUB]};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Idle cycles carry a zero payload
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      class_o     <= class_d;
      op_o        <= op_i;
      vew_o       <= vew_i;
      signed_o    <= signed_d;
      subtract_o  <= subtract_d;
      reverse_o   <= reverse_d;
      saturate_o  <= saturate_d;
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
    end else begin
      class_o     <= simd_op_pkg::CLS_NONE;
      op_o        <= simd_op_pkg::OP_AND;
      vew_o       <= simd_elem_pkg::EW8;
      signed_o    <= 1'b0;
      subtract_o  <= 1'b0;
      reverse_o   <= 1'b0;
      saturate_o  <= 1'b0;
      operand_a_o <= '0;
      operand_b_o <= '0;
    end
  end

endmodule

/* verilog/simd_alu_execute.sv */
`timescale 1ns/10ps

module simd_alu_execute (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  simd_op_pkg::alu_class_e class_i,
  input  simd_op_pkg::alu_op_e    op_i,
  input  simd_elem_pkg::vew_e     vew_i,
  input  logic                    signed_i,
  input  logic                    subtract_i,
  input  logic                    reverse_i,
  input  logic                    saturate_i,
  input  simd_elem_pkg::elen_t    operand_a_i,
  input  simd_elem_pkg::elen_t    operand_b_i,
  output logic                    valid_o,
  output simd_op_pkg::alu_class_e class_o,
  output simd_op_pkg::alu_op_e    op_o,
  output simd_elem_pkg::vew_e     vew_o,
  output logic                    signed_o,
  output logic                    saturate_o,
  output simd_elem_pkg::elen_t    operand_a_o,
  output simd_elem_pkg::elen_t    operand_b_o,
  output simd_elem_pkg::elen_t    raw_o,
  output simd_elem_pkg::strb_t    carry_o,
  output simd_elem_pkg::strb_t    less_o,
  output simd_elem_pkg::strb_t    equal_o
);

  simd_elem_pkg::elen_t add_x;
  simd_elem_pkg::elen_t add_y;
  simd_elem_pkg::elen_t add_in;
  simd_elem_pkg::elen_t sum;
  simd_elem_pkg::elen_t shift_res;
  simd_elem_pkg::elen_t logic_res;
  simd_elem_pkg::elen_t raw_d;
  simd_elem_pkg::strb_t carry;
  simd_elem_pkg::strb_t less;
  simd_elem_pkg::strb_t equal;

  //////////////////////////////
  // Segmented adder
  //////////////////////////////

  // Subtract is b - a, reverse subtract is a - b
  assign add_x  = reverse_i ? operand_a_i : operand_b_i;
  assign add_in = reverse_i ? operand_b_i : operand_a_i;
  assign add_y  = subtract_i ? ~add_in : add_in;

  always_comb begin : p_adder
    logic [8:0] part;
    logic       cin;
    int         nb;
    nb    = simd_elem_pkg::elem_bytes(vew_i);
    cin   = 1'b0;
    sum   = '0;
    carry = '0;
    for (int i = 0; i < simd_elem_pkg::StrbWidth; i++) begin
      // Chain restarts at every element boundary
      if ((i % nb) == 0) begin
        cin = subtract_i;
      end
      part = {1'b0, add_x[8*i +: 8]} + {1'b0, add_y[8*i +: 8]} + 9'(cin);
      sum[8*i +: 8] = part[7:0];
      cin = part[8];
      // Carry for add, borrow for subtract
      if ((i % nb) == nb - 1) begin
        carry[simd_elem_pkg::elem_base(vew_i, i)] = part[8] ^ subtract_i;
      end
    end
  end

  //////////////////////////////
  // Compare
  //////////////////////////////

  always_comb begin : p_compare
    logic lt;
    logic eq;
    int   nb;
    nb    = simd_elem_pkg::elem_bytes(vew_i);
    lt    = 1'b0;
    eq    = 1'b0;
    less  = '0;
    equal = '0;
    // Top byte first, lower bytes only break ties
    for (int i = simd_elem_pkg::StrbWidth - 1; i >= 0; i--) begin
      if ((i % nb) == nb - 1) begin
        lt = $signed({signed_i & operand_b_i[8*i+7], operand_b_i[8*i +: 8]}) <
             $signed({signed_i & operand_a_i[8*i+7], operand_a_i[8*i +: 8]});
        eq = operand_b_i[8*i +: 8] == operand_a_i[8*i +: 8];
      end else begin
        lt = lt | (eq & (operand_b_i[8*i +: 8] < operand_a_i[8*i +: 8]));
        eq = eq & (operand_b_i[8*i +: 8] == operand_a_i[8*i +: 8]);
      end
      if ((i % nb) == 0) begin
        less[i]  = lt;
        equal[i] = eq;
      end
    end
  end

  //////////////////////////////
  // Shifter and logic
  //////////////////////////////

  always_comb begin : p_shift
    logic [63:0] mask;
    logic [63:0] elem;
    logic [63:0] shifted;
    logic [5:0]  amt;
    int          nb;
    nb        = simd_elem_pkg::elem_bytes(vew_i);
    // Wraps to all ones for 64-bit elements
    mask      = (64'd1 << (8 * nb)) - 64'd1;
    elem      = '0;
    shifted   = '0;
    amt       = '0;
    shift_res = '0;
    for (int e = 0; e < simd_elem_pkg::StrbWidth; e++) begin
      if ((e % nb) == 0) begin
        elem = (operand_b_i >> (8 * e)) & mask;
        if (op_i == simd_op_pkg::OP_SRA && elem[8*nb-1]) begin
          elem = elem | ~mask;
        end
        amt = operand_a_i[8*e +: 6] & 6'(8 * nb - 1);
        case (op_i)
          simd_op_pkg::OP_SLL: shifted = elem << amt;
          simd_op_pkg::OP_SRA: shifted = $signed(elem) >>> amt;
          default:             shifted = elem >> amt;
        endcase
        for (int k = 0; k < simd_elem_pkg::StrbWidth; k++) begin
          if (k < nb) begin
            shift_res[8*(e+k) +: 8] = shifted[8*k +: 8];
          end
        end
      end
    end
  end

  always_comb begin : p_logic
    case (op_i)
      simd_op_pkg::OP_AND: logic_res = operand_a_i & operand_b_i;
      simd_op_pkg::OP_OR:  logic_res = operand_a_i | operand_b_i;
      simd_op_pkg::OP_XOR: logic_res = operand_a_i ^ operand_b_i;
      default:             logic_res = '0;
    endcase
  end

  // Min/max and compares resolve in retire
  always_comb begin : p_select
    case (class_i)
      simd_op_pkg::CLS_LOGIC: raw_d = logic_res;
      simd_op_pkg::CLS_ARITH: raw_d = sum;
      simd_op_pkg::CLS_SHIFT: raw_d = shift_res;
      default:                raw_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      class_o     <= class_i;
      op_o        <= op_i;
      vew_o       <= vew_i;
      signed_o    <= signed_i;
      saturate_o  <= saturate_i;
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
      raw_o       <= raw_d;
      carry_o     <= carry;
      less_o      <= less;
      equal_o     <= equal;
    end else begin
      class_o     <= simd_op_pkg::CLS_NONE;
      op_o        <= simd_op_pkg::OP_AND;
      vew_o       <= simd_elem_pkg::EW8;
      signed_o    <= 1'b0;
      saturate_o  <= 1'b0;
      operand_a_o <= '0;
      operand_b_o <= '0;
      raw_o       <= '0;
      carry_o     <= '0;
      less_o      <= '0;
      equal_o     <= '0;
    end
  end

endmodule

/* verilog/simd_alu_retire.sv */
`timescale 1ns/10ps

module simd_alu_retire (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  simd_op_pkg::alu_class_e class_i,
  input  simd_op_pkg::alu_op_e    op_i,
  input  simd_elem_pkg::vew_e     vew_i,
  input  logic                    signed_i,
  input  logic                    saturate_i,
  input  simd_elem_pkg::elen_t    operand_a_i,
  input  simd_elem_pkg::elen_t    operand_b_i,
  input  simd_elem_pkg::elen_t    raw_i,
  input  simd_elem_pkg::strb_t    carry_i,
  input  simd_elem_pkg::strb_t    less_i,
  input  simd_elem_pkg::strb_t    equal_i,
  output logic                    valid_o,
  output simd_elem_pkg::elen_t    result_o,
  output simd_elem_pkg::strb_t    vxsat_o
);

  simd_elem_pkg::elen_t result_d;
  simd_elem_pkg::strb_t vxsat_d;

  //////////////////////////////
  // Per-byte result assembly
  //////////////////////////////

  always_comb begin : p_retire
    logic       a_sign;
    logic       b_sign;
    logic       r_sign;
    logic       ovf;
    logic       sat;
    logic       pick_b;
    logic       truth;
    logic [7:0] clamp;
    int         nb;
    int         base;
    int         top;
    nb       = simd_elem_pkg::elem_bytes(vew_i);
    result_d = '0;
    vxsat_d  = '0;
    for (int i = 0; i < simd_elem_pkg::StrbWidth; i++) begin
      base   = simd_elem_pkg::elem_base(vew_i, i);
      top    = base + nb - 1;
      a_sign = operand_a_i[8*top+7];
      b_sign = operand_b_i[8*top+7];
      r_sign = raw_i[8*top+7];

      // Subtract is b - a, so b's sign is the true sign on overflow
      if (!signed_i) begin
        ovf = carry_i[base];
      end else if (op_i == simd_op_pkg::OP_SSUB) begin
        ovf = (a_sign != b_sign) && (r_sign != b_sign);
      end else begin
        ovf = (a_sign == b_sign) && (r_sign != a_sign);
      end
      sat = saturate_i && ovf;

      if (signed_i) begin
        clamp = (i == top) ? {b_sign, {7{~b_sign}}} : {8{~b_sign}};
      end else begin
        clamp = (op_i == simd_op_pkg::OP_SADDU) ? 8'hff : 8'h00;
      end

      // Max takes the opposite pick of min
      pick_b = less_i[base] ^ (op_i inside {simd_op_pkg::OP_MAXU, simd_op_pkg::OP_MAX});

      case (op_i)
        simd_op_pkg::OP_MSEQ:  truth = equal_i[base];
        simd_op_pkg::OP_MSNE:  truth = !equal_i[base];
        simd_op_pkg::OP_MSLTU,
        simd_op_pkg::OP_MSLT:  truth = less_i[base];
        simd_op_pkg::OP_MSLEU,
        simd_op_pkg::OP_MSLE:  truth = less_i[base] || equal_i[base];
        simd_op_pkg::OP_MSGTU,
        simd_op_pkg::OP_MSGT:  truth = !(less_i[base] || equal_i[base]);
        default:               truth = 1'b0;
      endcase

      case (class_i)
        simd_op_pkg::CLS_LOGIC,
        simd_op_pkg::CLS_SHIFT: begin
          result_d[8*i +: 8] = raw_i[8*i +: 8];
        end
        simd_op_pkg::CLS_ARITH: begin
          result_d[8*i +: 8] = sat ? clamp : raw_i[8*i +: 8];
          vxsat_d[i]         = sat;
        end
        simd_op_pkg::CLS_MINMAX: begin
          result_d[8*i +: 8] = pick_b ? operand_b_i[8*i +: 8] : operand_a_i[8*i +: 8];
        end
        simd_op_pkg::CLS_CMP: begin
          // Truth bit sits in the element's lowest bit
          result_d[8*i +: 8] = {7'b0, truth && (i == base)};
        end
        default: begin
          result_d[8*i +: 8] = 8'h00;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Outputs read zero whenever valid_o is low
  always_ff @(posedge clk_i) begin
    if (rst_i || !valid_i) begin
      result_o <= '0;
      vxsat_o  <= '0;
    end else begin
      result_o <= result_d;
      vxsat_o  <= vxsat_d;
    end
  end

endmodule

/* verilog/simd_alu.sv */
`timescale 1ns/10ps

module simd_alu (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  simd_op_pkg::alu_op_e op_i,
  input  simd_elem_pkg::vew_e  vew_i,
  input  simd_elem_pkg::elen_t operand_a_i,
  input  simd_elem_pkg::elen_t operand_b_i,
  output logic                 valid_o,
  output simd_elem_pkg::elen_t result_o,
  output simd_elem_pkg::strb_t vxsat_o
);

  // Issue to execute
  logic                    iss_valid;
  simd_op_pkg::alu_class_e iss_class;
  simd_op_pkg::alu_op_e    iss_op;
  simd_elem_pkg::vew_e     iss_vew;
  logic                    iss_signed;
  logic                    iss_subtract;
  logic                    iss_reverse;
  logic                    iss_saturate;
  simd_elem_pkg::elen_t    iss_operand_a;
  simd_elem_pkg::elen_t    iss_operand_b;

  // Execute to retire
  logic                    exe_valid;
  simd_op_pkg::alu_class_e exe_class;
  simd_op_pkg::alu_op_e    exe_op;
  simd_elem_pkg::vew_e     exe_vew;
  logic                    exe_signed;
  logic                    exe_saturate;
  simd_elem_pkg::elen_t    exe_operand_a;
  simd_elem_pkg::elen_t    exe_operand_b;
  simd_elem_pkg::elen_t    exe_raw;
  simd_elem_pkg::strb_t    exe_carry;
  simd_elem_pkg::strb_t    exe_less;
  simd_elem_pkg::strb_t    exe_equal;

  simd_alu_issue i_issue (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (iss_valid),
    .class_o     (iss_class),
    .op_o        (iss_op),
    .vew_o       (iss_vew),
    .signed_o    (iss_signed),
    .subtract_o  (iss_subtract),
    .reverse_o   (iss_reverse),
    .saturate_o  (iss_saturate),
    .operand_a_o (iss_operand_a),
    .operand_b_o (iss_operand_b)
  );

  simd_alu_execute i_execute (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (iss_valid),
    .class_i     (iss_class),
    .op_i        (iss_op),
    .vew_i       (iss_vew),
    .signed_i    (iss_signed),
    .subtract_i  (iss_subtract),
    .reverse_i   (iss_reverse),
    .saturate_i  (iss_saturate),
    .operand_a_i (iss_operand_a),
    .operand_b_i (iss_operand_b),
    .valid_o     (exe_valid),
    .class_o     (exe_class),
    .op_o        (exe_op),
    .vew_o       (exe_vew),
    .signed_o    (exe_signed),
    .saturate_o  (exe_saturate),
    .operand_a_o (exe_operand_a),
    .operand_b_o (exe_operand_b),
    .raw_o       (exe_raw),
    .carry_o     (exe_carry),
    .less_o      (exe_less),
    .equal_o     (exe_equal)
  );

  simd_alu_retire i_retire (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (exe_valid),
    .class_i     (exe_class),
    .op_i        (exe_op),
    .vew_i       (exe_vew),
    .signed_i    (exe_signed),
    .saturate_i  (exe_saturate),
    .operand_a_i (exe_operand_a),
    .operand_b_i (exe_operand_b),
    .raw_i       (exe_raw),
    .carry_i     (exe_carry),
    .less_i      (exe_less),
    .equal_i     (exe_equal),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

endmodule

/* verif/simd_alu_asserts.sv */
`timescale 1ns/10ps

module simd_alu_asserts (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 valid_i,
  input logic                 valid_o,
  input simd_elem_pkg::strb_t vxsat_o
);

  property valid_clear_after_reset;
    @(posedge clk_i) rst_i |=> !valid_o;
  endproperty

  // Three stage latency, never stalls
  property valid_latency;
    @(posedge clk_i) disable iff (rst_i) valid_i |-> ##3 valid_o;
  endproperty

  property vxsat_zero_when_idle;
    @(posedge clk_i) disable iff (rst_i) !valid_o |-> vxsat_o == '0;
  endproperty

  a_valid_clear_after_reset : assert property (valid_clear_after_reset)
    else $error("valid_o high in the cycle after reset");

  a_valid_latency : assert property (valid_latency)
    else $error("valid_o missing three cycles after valid_i");

  a_vxsat_zero_when_idle : assert property (vxsat_zero_when_idle)
    else $error("vxsat_o not zero while valid_o is low");

endmodule

/* verif/simd_alu_tb.sv */
`timescale 1ns/10ps

module simd_alu_tb;

  localparam int    ResetCycles = 8;
  localparam string GoldenFile  = "verif/simd_alu_golden.txt";

  logic                 clk_i;
  logic                 rst_i;
  logic                 valid_i;
  simd_op_pkg::alu_op_e op_i;
  simd_elem_pkg::vew_e  vew_i;
  simd_elem_pkg::elen_t operand_a_i;
  simd_elem_pkg::elen_t operand_b_i;
  logic                 valid_o;
  simd_elem_pkg::elen_t result_o;
  simd_elem_pkg::strb_t vxsat_o;

  // Vectors as read from the golden file
  simd_op_pkg::alu_op_e vec_op[$];
  simd_elem_pkg::vew_e  vec_vew[$];
  simd_elem_pkg::elen_t vec_a[$];
  simd_elem_pkg::elen_t vec_b[$];
  simd_elem_pkg::elen_t vec_result[$];
  simd_elem_pkg::strb_t vec_vxsat[$];

  // Operations in flight, oldest first
  simd_op_pkg::alu_op_e exp_op_q[$];
  simd_elem_pkg::elen_t exp_result_q[$];
  simd_elem_pkg::strb_t exp_vxsat_q[$];

  logic [2:0] valid_pipe;
  int         error_count;
  int         check_count;
  int         cycle_count;
  int         cycle_limit;
  int         seed;

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  simd_alu i_simd_alu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

  bind simd_alu simd_alu_asserts i_simd_alu_asserts (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .valid_o (valid_o),
    .vxsat_o (vxsat_o)
  );

  //////////////////////////////
  // Golden file and reporting
  //////////////////////////////

  task automatic load_vectors();
    int          fd;
    int          count;
    string       line;
    logic [4:0]  op_raw;
    logic [1:0]  vew_raw;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [7:0]  sat;
    fd = $fopen(GoldenFile, "r");
    if (fd == 0) begin
      $display("Could not open the golden file %s", GoldenFile);
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Lines starting with # hold column notes
      if (line.len() > 0 && line.getc(0) != "#") begin
        count = $sscanf(line, "%h %h %h %h %h %h", op_raw, vew_raw, a, b, res, sat);
        if (count == 6) begin
          vec_op.push_back(simd_op_pkg::alu_op_e'(op_raw));
          vec_vew.push_back(simd_elem_pkg::vew_e'(vew_raw));
          vec_a.push_back(a);
          vec_b.push_back(b);
          vec_result.push_back(res);
          vec_vxsat.push_back(sat);
        end
      end
    end
    $fclose(fd);
    if (vec_op.size() == 0) begin
      $display("The golden file holds no vectors");
      error_count++;
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d, checked: %0d", error_count, check_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic apply_vector(int idx);
    valid_i     <= 1'b1;
    op_i        <= vec_op[idx];
    vew_i       <= vec_vew[idx];
    operand_a_i <= vec_a[idx];
    operand_b_i <= vec_b[idx];
    exp_op_q.push_back(vec_op[idx]);
    exp_result_q.push_back(vec_result[idx]);
    exp_vxsat_q.push_back(vec_vxsat[idx]);
  endtask

  initial begin : stimulus
    int gap;
    seed        = 49347;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    cycle_limit = 0;
    rst_i       = 1'b1;
    // Saturating operation held live early in reset
    valid_i     = 1'b1;
    op_i        = simd_op_pkg::OP_SADDU;
    vew_i       = simd_elem_pkg::EW8;
    operand_a_i = '1;
    operand_b_i = '1;
    load_vectors();
    cycle_limit = ResetCycles + 3 * vec_op.size() + 20;
    repeat (ResetCycles / 2) @(posedge clk_i);
    valid_i <= 1'b0;
    repeat (ResetCycles - ResetCycles / 2) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int i = 0; i < vec_op.size(); i++) begin
      apply_vector(i);
      @(posedge clk_i);
      // Zero gap keeps vectors back to back
      gap = {$random(seed)} % 3;
      if (gap > 0) begin
        valid_i <= 1'b0;
        repeat (gap) @(posedge clk_i);
      end
    end
    valid_i <= 1'b0;
    while (exp_result_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    finish_run();
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_i);
    end
    $display("Timeout after %0d cycles, %0d results never came out",
             cycle_count, exp_result_q.size());
    error_count++;
    finish_run();
  end

  //////////////////////////////
  // Output checks
  //////////////////////////////

  // valid_i reaches valid_o through three register stages
  always @(posedge clk_i) begin
    if (rst_i) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[1:0], valid_i};
    end
    cycle_count <= cycle_count + 1;
  end

  task automatic check_outputs();
    simd_op_pkg::alu_op_e exp_op;
    simd_elem_pkg::elen_t exp_result;
    simd_elem_pkg::strb_t exp_vxsat;
    assert (valid_o === valid_pipe[2]) else begin
      $display("[FAIL] %0t valid_o is %b, expected %b", $time, valid_o, valid_pipe[2]);
      error_count++;
    end
    if (valid_o !== 1'b1) begin
      assert (result_o === '0 && vxsat_o === '0) else begin
        $display("[FAIL] %0t idle outputs not zero, result %h vxsat %h",
                 $time, result_o, vxsat_o);
        error_count++;
      end
    end else if (exp_result_q.size() == 0) begin
      $display("valid_o went high at %0t with no operation in flight", $time);
      error_count++;
    end else begin
      exp_op     = exp_op_q.pop_front();
      exp_result = exp_result_q.pop_front();
      exp_vxsat  = exp_vxsat_q.pop_front();
      check_count++;
      assert (result_o === exp_result && vxsat_o === exp_vxsat) else begin
        $display("[FAIL] %0t op %0h %s expected %h/%h, got %h/%h", $time, exp_op,
                 exp_op.name(), exp_result, exp_vxsat, result_o, vxsat_o);
        error_count++;
      end
    end
  endtask

  // Falling edge, away from the register updates
  always @(negedge clk_i) begin
    if (cycle_count > 0) begin
      check_outputs();
    end
  end

endmodule

/* verif/simd_alu_golden.txt */
# op vew operand_a operand_b result vxsat, all hex
# vew 0 to 3 selects 8, 16, 32 or 64 bit elements
00 0 ff00ff0012345678 0f0f0f0fffff0000 0f000f0012340000 00
01 1 00f000f000000001 0f000f0010000000 0ff00ff010000001 00
02 0 aaaaaaaa55555555 ffffffff0000ffff 555555555555aaaa 00
03 0 ff01807f00000001 01ff8001000000ff 0000008000000000 00
03 1 ffff1234800100ff 00020ff080000f01 0001222400011000 00
03 2 ffffffff7fffffff 0000000100000001 0000000080000000 00
03 3 ffffffffffffffff 0000000000000002 0000000000000001 00
04 1 00010005ffff1000 0000000300012000 fffffffe00021000 00
05 2 0000000500000000 0000000300000001 00000002ffffffff 00
06 0 f01080010000007f 201080fe0000007f ff20ffff000000fe a0
07 1 7fff80000001fff0 0001ffff00020010 7fff800000030000 f0
08 2 0000001000000001 00000005ffffffff 00000000fffffffe f0
09 0 01ff7f8001000000 807f807f05000000 807f807f04000000 f0
0a 0 8001ff1000000000 7f02011000000000 7f01011000000000 00
0b 0 8001ff1000000000 7f02011000000000 8001ff1000000000 00
0c 1 80000001ffff1234 7fff000200011234 80000002ffff1234 00
0d 1 80000001ffff1234 7fff000200011234 7fff000200011234 00
0e 0 10101080ff010000 1020057f01ff0000 0100000000000101 00
0f 0 10101080ff010000 1020057f01ff0000 0001010101010000 00
10 0 10101080ff010000 1020057f01ff0000 0000010101000000 00
11 0 10101080ff010000 1020057f01ff0000 0000010000010000 00
13 0 10101080ff010000 1020057f01ff0000 0100010000010101 00
14 0 10101080ff010000 1020057f01ff0000 0001000000010000 00
15 0 10101080ff010000 1020057f01ff0000 0001000101000000 00
11 2 00000010ffffffff 0000000500000001 0000000100000000 00
16 0 0109ff0002030807 818181810ff0ff01 020280813c80ff80 00
17 1 00040011000f0000 80008000ffff1234 0800400000011234 00
18 2 000000240000001f 800000007fffffff f800000000000000 00
18 0 010907040100030f 80fe807f01c0f081 c0ffff0700c0feff 00
1a 3 ffffffffffffffff ffffffffffffffff 0000000000000000 00

/* simd_alu.f */
verilog/simd_elem_pkg.sv
verilog/simd_op_pkg.sv
verilog/simd_alu_issue.sv
verilog/simd_alu_execute.sv
verilog/simd_alu_retire.sv
verilog/simd_alu.sv
verif/simd_alu_asserts.sv
verif/simd_alu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module simd_alu_tb -f simd_alu.f -o simd_alu_sim

./obj_dir/simd_alu_sim 2>&1 | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
